/* build.f */
+incdir+.
noc_route_pkg.sv
noc_msg_pkg.sv
noc_dst_decoder.sv
noc_splitter.sv
noc_out_buffer.sv
noc_split_top.sv
tb_noc_split.sv

/* noc_consts.svh */
`ifndef NOC_CONSTS_SVH
`define NOC_CONSTS_SVH

// Flit width in bits.
`define NOC_DATA_W 64

// Width of the header payload length field.
`define MSG_LEN_W 8

// Number of destination ports.
`define NUM_TARGETS 3

`endif

/* noc_dst_decoder.sv */
`timescale 1ns/1ns
`default_nettype none

`include "noc_consts.svh"

module noc_dst_decoder (
    input  wire [`NOC_DATA_W-1:0]       noc_data_line,
    output noc_route_pkg::dst_sel_t     dst_sel_one_hot
);

    import noc_msg_pkg::*;
    import noc_route_pkg::*;

    noc_flit_u  flit;
    dst_id_t    dst_id;

    assign flit   = noc_data_line;
    assign dst_id = flit.hdr.dst_id;

    always_comb begin
        dst_sel_one_hot = '0;
        if (int'(dst_id) < `NUM_TARGETS) begin
            dst_sel_one_hot[dst_id] = 1'b1;
        end else begin
            dst_sel_one_hot[`NUM_TARGETS-1] = 1'b1;  // Overflow id to last port.
        end
    end

endmodule

`default_nettype wire

/* noc_msg_pkg.sv */
`default_nettype none

`include "noc_consts.svh"

package noc_msg_pkg;

    localparam int HDR_PAYLOAD_W = `NOC_DATA_W - $bits(noc_route_pkg::dst_id_t) - `MSG_LEN_W;

    typedef struct packed {
        noc_route_pkg::dst_id_t     dst_id;       // Top bits of the flit.
        logic [`MSG_LEN_W-1:0]      payload_len;  // Body flits that follow.
        logic [HDR_PAYLOAD_W-1:0]   hdr_payload;
    } noc_hdr_t;

    // One flit word, read as a header or carried as raw body data.
    typedef union packed {
        noc_hdr_t                   hdr;
        logic [`NOC_DATA_W-1:0]     raw;
    } noc_flit_u;

endpackage

`default_nettype wire

/* noc_out_buffer.sv */
`timescale 1ns/1ns
`default_nettype none

`include "noc_consts.svh"

module noc_out_buffer (
    input  wire                         clk,
    input  wire                         rst,

    input  wire                         in_val,
    input  wire  [`NOC_DATA_W-1:0]      in_data,
    output logic                        in_rdy,

    output logic                        out_val,
    output logic [`NOC_DATA_W-1:0]      out_data,
    input  wire                         out_rdy
);

    logic [1:0][`NOC_DATA_W-1:0]    mem;
    logic                           wr_ptr;
    logic                           rd_ptr;
    logic [1:0]                     count;

    logic                           full;
    logic                           push;
    logic                           pop;

    assign full = (count == 2'd2);

    // A full buffer still takes a flit while one leaves.
    assign in_rdy = ~full | out_rdy;

    assign out_val  = (count != 2'd0);
    assign out_data = mem[rd_ptr];

    assign push = in_val & in_rdy;
    assign pop  = out_val & out_rdy;

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= in_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= 1'b0;
            rd_ptr <= 1'b0;
            count  <= 2'd0;
        end else begin
            if (push) begin
                wr_ptr <= ~wr_ptr;
            end
            if (pop) begin
                rd_ptr <= ~rd_ptr;
            end
            case ({push, pop})
                2'b10:   count <= count + 2'd1;
                2'b01:   count <= count - 2'd1;
                default: count <= count;  // Idle or pass through.
            endcase
        end
    end

endmodule

`default_nettype wire

/* noc_route_pkg.sv */
`default_nettype none

`include "noc_consts.svh"

package noc_route_pkg;

    // Ids 0 to 2 name a target, id 3 is the overflow id.
    typedef logic [1:0] dst_id_t;

    // One bit per destination port.
    typedef logic [`NUM_TARGETS-1:0] dst_sel_t;

endpackage

`default_nettype wire

/* noc_split_top.sv */
`timescale 1ns/1ns
`default_nettype none

`include "noc_consts.svh"

module noc_split_top (
    input  wire                                         clk,
    input  wire                                         rst,

    input  wire                                         in_val,
    input  wire  [`NOC_DATA_W-1:0]                      in_data,
    output logic                                        in_rdy,

    output logic [`NUM_TARGETS-1:0]                     dst_val,
    output logic [`NUM_TARGETS-1:0][`NOC_DATA_W-1:0]    dst_data,
    input  wire  [`NUM_TARGETS-1:0]                     dst_rdy
);

    import noc_route_pkg::*;

    logic [`NOC_DATA_W-1:0]                     noc_data_line;
    dst_sel_t                                   dst_sel_one_hot;

    logic [`NUM_TARGETS-1:0]                    split_val;
    logic [`NUM_TARGETS-1:0][`NOC_DATA_W-1:0]   split_data;
    logic [`NUM_TARGETS-1:0]                    split_rdy;

    noc_dst_decoder dst_decoder_inst (
        .noc_data_line   (noc_data_line),
        .dst_sel_one_hot (dst_sel_one_hot)
    );

    noc_splitter splitter_inst (
        .clk             (clk),
        .rst             (rst),
        .src_val         (in_val),
        .src_data        (in_data),
        .src_rdy         (in_rdy),
        .dsts_val        (split_val),
        .dsts_data       (split_data),
        .dsts_rdy        (split_rdy),
        .noc_data_line   (noc_data_line),
        .dst_sel_one_hot (dst_sel_one_hot)
    );

    for (genvar k = 0; k < `NUM_TARGETS; k++) begin : g_buf
        noc_out_buffer out_buffer_inst (
            .clk      (clk),
            .rst      (rst),
            .in_val   (split_val[k]),
            .in_data  (split_data[k]),
            .in_rdy   (split_rdy[k]),
            .out_val  (dst_val[k]),
            .out_data (dst_data[k]),
            .out_rdy  (dst_rdy[k])
        );
    end

endmodule

`default_nettype wire

/* noc_splitter.sv */
`timescale 1ns/1ns
`default_nettype none

`include "noc_consts.svh"

module noc_splitter (
    input  wire                                         clk,
    input  wire                                         rst,

    input  wire                                         src_val,
    input  wire  [`NOC_DATA_W-1:0]                      src_data,
    output logic                                        src_rdy,

    output logic [`NUM_TARGETS-1:0]                     dsts_val,
    output logic [`NUM_TARGETS-1:0][`NOC_DATA_W-1:0]    dsts_data,
    input  wire  [`NUM_TARGETS-1:0]                     dsts_rdy,

    output logic [`NOC_DATA_W-1:0]                      noc_data_line,
    input  wire  noc_route_pkg::dst_sel_t               dst_sel_one_hot
);

    import noc_msg_pkg::*;
    import noc_route_pkg::*;

    localparam logic ST_HDR  = 1'b0;
    localparam logic ST_BODY = 1'b1;

    logic                   state_reg;
    logic                   state_next;

    logic [`MSG_LEN_W-1:0]  count_reg;
    logic [`MSG_LEN_W-1:0]  count_next;

    dst_sel_t               sel_reg;
    dst_sel_t               sel_next;
    dst_sel_t               route_sel;

    noc_flit_u              flit;
    logic                   accept;

    assign flit          = src_data;
    assign noc_data_line = flit.raw;

    // Body flits keep the select latched from their header.
    assign route_sel = (state_reg == ST_BODY) ? sel_reg : dst_sel_one_hot;

    // One-hot demux of valid, one-hot mux of ready.
    assign dsts_val = route_sel & {`NUM_TARGETS{src_val}};
    assign src_rdy  = |(route_sel & dsts_rdy);

    assign accept = src_val & src_rdy;

    always_comb begin
        for (int i = 0; i < `NUM_TARGETS; i++) begin
            dsts_data[i] = flit.raw;
        end
    end

    always_comb begin
        state_next = state_reg;
        count_next = count_reg;
        sel_next   = sel_reg;

        case (state_reg)
            ST_HDR: begin
                if (accept) begin
                    count_next = flit.hdr.payload_len;
                    sel_next   = dst_sel_one_hot;
                    if (flit.hdr.payload_len != '0) begin
                        state_next = ST_BODY;
                    end
                end
            end
            ST_BODY: begin
                if (accept) begin
                    count_next = count_reg - 1'b1;
                    if (count_reg == `MSG_LEN_W'(1)) begin
                        state_next = ST_HDR;  // Last body flit.
                    end
                end
            end
            default: begin
                state_next = ST_HDR;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_reg <= ST_HDR;
            count_reg <= '0;
            sel_reg   <= '0;
        end else begin
            state_reg <= state_next;
            count_reg <= count_next;
            sel_reg   <= sel_next;
        end
    end

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# Build and run the NoC splitter testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f build.f --top-module tb_noc_split -o tb_noc_split
if [ $? -ne 0 ]; then
    echo "Verilator compile failed"
    exit 1
fi

out=$(./obj_dir/tb_noc_split)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qx "TEST PASS"; then
    exit 0
fi
echo "Pass message not found"
exit 1

/* tb_noc_split.sv */
`timescale 1ns/1ns
`default_nettype none

`include "noc_consts.svh"

module tb_noc_split;

    import noc_msg_pkg::*;

    localparam int WAIT_LIMIT = 200;

    logic                                       clk;
    logic                                       rst;
    logic                                       in_val;
    logic [`NOC_DATA_W-1:0]                     in_data;
    logic                                       in_rdy;
    logic [`NUM_TARGETS-1:0]                    dst_val;
    logic [`NUM_TARGETS-1:0][`NOC_DATA_W-1:0]   dst_data;
    logic [`NUM_TARGETS-1:0]                    dst_rdy;

    logic [31:0]            lfsr;
    logic [`NOC_DATA_W-1:0] exp_q [`NUM_TARGETS][$];  // Expected flits per target.
    logic                   rdy_random;
    logic                   stalled;
    int                     n_checks;
    int                     n_errors;
    int                     n_tests;

    noc_split_top noc_split_top_inst (
        .clk      (clk),
        .rst      (rst),
        .in_val   (in_val),
        .in_data  (in_data),
        .in_rdy   (in_rdy),
        .dst_val  (dst_val),
        .dst_data (dst_data),
        .dst_rdy  (dst_rdy)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    task automatic take_bits(input int n, output logic [63:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            v    = {v[62:0], lfsr[0]};
            lfsr = lfsr_next(lfsr);
        end
    endtask

    function automatic int expected_target(input noc_hdr_t hdr);
        int t;
        case (hdr.dst_id)
            2'd0:    t = 0;
            2'd1:    t = 1;
            2'd2:    t = 2;
            default: t = 2;  // Overflow id.
        endcase
        return t;
    endfunction

    task automatic check_value(input logic [63:0] got, input logic [63:0] exp, input string what);
        n_checks++;
        if (got !== exp) begin
            $display("ERROR: %0t ns %s: got %h, expected %h", $time, what, got, exp);
            n_errors++;
        end
    endtask

    task automatic step_cycle();
        logic [63:0] r;
        @(posedge clk);
        #1;
        if (rdy_random) begin
            take_bits(`NUM_TARGETS, r);
            dst_rdy = r[`NUM_TARGETS-1:0];
        end else begin
            dst_rdy = '1;
        end
    endtask

    task automatic send_flit(input logic [`NOC_DATA_W-1:0] flit, input int tgt);
        int   cycles;
        logic done;
        cycles  = 0;
        done    = 1'b0;
        in_val  = 1'b1;
        in_data = flit;
        while (!done && !stalled) begin
            @(negedge clk);
            done = in_rdy;
            cycles++;
            if (!done && cycles >= WAIT_LIMIT) begin
                $display("Timeout: in_rdy stayed low for %0d cycles at %0t ns", cycles, $time);
                stalled = 1'b1;
            end
            step_cycle();
            if (done) begin
                exp_q[tgt].push_back(flit);  // Accepted on the last edge.
            end
        end
        in_val = 1'b0;
    endtask

    task automatic send_message(input logic [1:0] id, input int len, input int body_top);
        noc_flit_u   f;
        logic [63:0] r;
        int          tgt;
        take_bits(54, r);
        f.hdr.dst_id      = id;
        f.hdr.payload_len = `MSG_LEN_W'(len);
        f.hdr.hdr_payload = r[53:0];
        tgt = expected_target(f.hdr);
        send_flit(f.raw, tgt);
        for (int i = 0; i < len; i++) begin
            take_bits(64, r);
            if (body_top >= 0) begin
                r[63:62] = body_top[1:0];  // Top bits that decode elsewhere.
            end
            send_flit(r, tgt);
        end
    endtask

    task automatic random_messages(input int count);
        logic [63:0] r;
        logic [63:0] len;
        for (int i = 0; i < count; i++) begin
            take_bits(2, r);
            take_bits(3, len);
            send_message(r[1:0], int'(len) % 6, -1);
        end
    endtask

    task automatic end_test(input string name, input int err_before);
        int cycles;
        cycles = 0;
        while (!stalled && (exp_q[0].size() + exp_q[1].size() + exp_q[2].size() != 0)) begin
            step_cycle();
            cycles++;
            if (cycles >= WAIT_LIMIT) begin
                $display("Timeout: expected flits still queued after %0d cycles", cycles);
                stalled = 1'b1;
            end
        end
        check_value(64'(dst_val), '0, "dst_val after drain");
        n_tests++;
        $display("Test %0d %s: %0d errors", n_tests, name, n_errors - err_before);
    endtask

    for (genvar k = 0; k < `NUM_TARGETS; k++) begin : g_cmp
        always @(negedge clk) begin
            if (!rst && dst_val[k] && dst_rdy[k]) begin
                if (exp_q[k].size() == 0) begin
                    $display("ERROR: %0t ns unexpected flit %h on target %0d",
                             $time, dst_data[k], k);
                    n_errors++;
                end else begin
                    check_value(dst_data[k], exp_q[k].pop_front(),
                                $sformatf("target %0d data", k));
                end
            end
        end
    end

    initial begin
        int err0;
        rst        = 1'b1;
        in_val     = 1'b0;
        in_data    = '0;
        dst_rdy    = '1;
        rdy_random = 1'b0;
        stalled    = 1'b0;
        lfsr       = 32'he33f4103;
        n_checks   = 0;
        n_errors   = 0;
        n_tests    = 0;
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;

        err0 = n_errors;
        for (int i = 0; i < 5; i++) begin
            step_cycle();
            check_value(64'(dst_val), '0, "dst_val after reset");
        end
        end_test("idle after reset", err0);

        err0 = n_errors;
        for (int id = 0; id < 3; id++) begin
            send_message(id[1:0], 0, -1);
        end
        end_test("zero length per id", err0);

        err0 = n_errors;
        for (int id = 0; id < 3; id++) begin
            send_message(id[1:0], 3, (id + 1) % 3);
        end
        end_test("body follows header", err0);

        err0 = n_errors;
        send_message(2'd3, 4, 0);
        end_test("overflow id", err0);

        err0 = n_errors;
        rdy_random = 1'b1;
        random_messages(30);
        end_test("random back-pressure", err0);

        err0 = n_errors;
        rdy_random = 1'b0;
        random_messages(200);
        end_test("long random mix", err0);

        $display("Summary: %0d tests, %0d checks, %0d errors", n_tests, n_checks, n_errors);
        if (n_errors == 0 && !stalled) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire
